//--- csr_addr_pkg.sv
package csr_addr_pkg;

    // width of every CSR and of the pc
    localparam int XLEN = 64;

    typedef logic [11:0] csr_addr_t;

    // machine-mode CSR addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET = 12'hB02;

    // mstatus fields kept by this unit
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // positions in mie and mip
    localparam int IRQ_MSI_BIT = 3;
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

    // interrupt codes, low bits of mcause
    typedef enum logic [3:0] {
        CAUSE_MSI = 4'd3,
        CAUSE_MTI = 4'd7,
        CAUSE_MEI = 4'd11
    } irq_cause_e;

endpackage

//--- csr_types_pkg.sv
package csr_types_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // one instruction leaving the commit stage
    typedef struct packed {
        logic                            valid;
        logic [csr_addr_pkg::XLEN-1:0]   pc;
        logic                            except;
        logic [csr_addr_pkg::XLEN-1:0]   ecause;
        logic [csr_addr_pkg::XLEN-1:0]   tval;
        logic                            mret;
        logic                            csr_we;
        csr_addr_pkg::csr_addr_t         csr_addr;
        logic [csr_addr_pkg::XLEN-1:0]   csr_wdata;
    } commit_t;

    // external interrupt lines
    typedef struct packed {
        logic meip;
        logic msip;
        logic mtip;
    } irq_lines_t;

    typedef struct packed {
        logic                          valid;
        logic [csr_addr_pkg::XLEN-1:0] target;
    } redirect_t;

    // written into mepc, mcause and mtval when a trap is taken
    typedef struct packed {
        logic                          take;
        logic [csr_addr_pkg::XLEN-1:0] epc;
        logic [csr_addr_pkg::XLEN-1:0] cause;
        logic [csr_addr_pkg::XLEN-1:0] tval;
    } trap_update_t;

endpackage

//--- csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_types_pkg::commit_t        commit,
    input  logic                          irq_pending,
    input  csr_addr_pkg::irq_cause_e      irq_cause,
    input  logic [csr_addr_pkg::XLEN-1:0] mtvec,
    input  logic [csr_addr_pkg::XLEN-1:0] mepc,
    output csr_types_pkg::trap_update_t   trap,
    output logic                          wr_en,
    output logic                          retire,
    output csr_types_pkg::redirect_t      redirect,
    output csr_types_pkg::priv_e          priv,
    output logic [csr_addr_pkg::XLEN-1:0] mstatus
);

    logic                          take_irq;
    logic                          take_trap;
    logic                          do_mret;
    logic                          mstatus_we;
    logic                          mie_q;
    logic                          mpie_q;
    csr_types_pkg::priv_e          mpp_q;
    logic [csr_addr_pkg::XLEN-1:0] irq_word;

    // interrupt wins over exception, both win over mret and csr write
    assign take_irq   = commit.valid & irq_pending;
    assign take_trap  = take_irq | (commit.valid & commit.except);
    assign do_mret    = commit.valid & commit.mret & ~take_trap;
    assign wr_en      = commit.valid & commit.csr_we & ~take_trap;
    assign retire     = commit.valid & ~take_trap & ~do_mret;
    assign mstatus_we = wr_en & (commit.csr_addr == csr_addr_pkg::CSR_MSTATUS);

    // interrupt bit on top, code below
    always_comb begin
        irq_word = '0;
        irq_word[3:0] = irq_cause;
        irq_word[csr_addr_pkg::XLEN-1] = 1'b1;
    end

    always_comb begin
        trap.take  = take_trap;
        trap.epc   = commit.pc;
        trap.cause = take_irq ? irq_word : commit.ecause;
        trap.tval  = take_irq ? '0 : commit.tval;
    end

    always_comb begin
        redirect.valid  = take_trap | do_mret;
        redirect.target = take_trap ? mtvec : mepc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv   <= csr_types_pkg::PRIV_M;
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
            mpp_q  <= csr_types_pkg::PRIV_U;
        end else if (take_trap) begin
            priv   <= csr_types_pkg::PRIV_M;
            mie_q  <= 1'b0;
            mpie_q <= mie_q;
            mpp_q  <= priv;
        end else if (do_mret) begin
            priv   <= mpp_q;
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
            mpp_q  <= csr_types_pkg::PRIV_U;
        end else if (mstatus_we) begin
            mie_q  <= commit.csr_wdata[csr_addr_pkg::MSTATUS_MIE_BIT];
            mpie_q <= commit.csr_wdata[csr_addr_pkg::MSTATUS_MPIE_BIT];
            // only M and U exist, anything but M becomes U
            mpp_q  <= (commit.csr_wdata[csr_addr_pkg::MSTATUS_MPP_LSB +: 2] ==
                       csr_types_pkg::PRIV_M) ? csr_types_pkg::PRIV_M : csr_types_pkg::PRIV_U;
        end
    end

    always_comb begin
        mstatus = '0;
        mstatus[csr_addr_pkg::MSTATUS_MIE_BIT]      = mie_q;
        mstatus[csr_addr_pkg::MSTATUS_MPIE_BIT]     = mpie_q;
        mstatus[csr_addr_pkg::MSTATUS_MPP_LSB +: 2] = mpp_q;
    end

endmodule

//--- csr_irq_arbiter.sv
`timescale 1ns/1ps

module csr_irq_arbiter (
    input  logic [csr_addr_pkg::XLEN-1:0] mie,
    input  logic [csr_addr_pkg::XLEN-1:0] mip,
    input  csr_types_pkg::priv_e          priv,
    input  logic                          mstatus_mie,
    output logic                          irq_pending,
    output csr_addr_pkg::irq_cause_e      irq_cause
);

    logic [csr_addr_pkg::XLEN-1:0] enabled;
    logic                          global_en;

    assign enabled   = mie & mip;
    // U mode always takes M interrupts
    assign global_en = (priv == csr_types_pkg::PRIV_U) | mstatus_mie;
    assign irq_pending = (|enabled) & global_en;

    // MEI > MSI > MTI
    always_comb begin
        if (enabled[csr_addr_pkg::IRQ_MEI_BIT]) begin
            irq_cause = csr_addr_pkg::CAUSE_MEI;
        end else if (enabled[csr_addr_pkg::IRQ_MSI_BIT]) begin
            irq_cause = csr_addr_pkg::CAUSE_MSI;
        end else begin
            irq_cause = csr_addr_pkg::CAUSE_MTI;
        end
    end

endmodule

//--- csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  csr_addr_pkg::csr_addr_t       csr_addr,
    input  logic [csr_addr_pkg::XLEN-1:0] csr_wdata,
    input  csr_types_pkg::trap_update_t   trap,
    input  csr_types_pkg::irq_lines_t     irq,
    output logic [csr_addr_pkg::XLEN-1:0] mtvec,
    output logic [csr_addr_pkg::XLEN-1:0] mscratch,
    output logic [csr_addr_pkg::XLEN-1:0] mepc,
    output logic [csr_addr_pkg::XLEN-1:0] mcause,
    output logic [csr_addr_pkg::XLEN-1:0] mtval,
    output logic [csr_addr_pkg::XLEN-1:0] mie,
    output logic [csr_addr_pkg::XLEN-1:0] mip
);

    logic [csr_addr_pkg::XLEN-1:0] mie_wmask;

    always_comb begin
        mie_wmask = '0;
        mie_wmask[csr_addr_pkg::IRQ_MSI_BIT] = 1'b1;
        mie_wmask[csr_addr_pkg::IRQ_MTI_BIT] = 1'b1;
        mie_wmask[csr_addr_pkg::IRQ_MEI_BIT] = 1'b1;
    end

    // mip follows the lines directly
    always_comb begin
        mip = '0;
        mip[csr_addr_pkg::IRQ_MSI_BIT] = irq.msip;
        mip[csr_addr_pkg::IRQ_MTI_BIT] = irq.mtip;
        mip[csr_addr_pkg::IRQ_MEI_BIT] = irq.meip;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mie      <= '0;
        end else if (trap.take) begin
            mepc   <= trap.epc;
            mcause <= trap.cause;
            mtval  <= trap.tval;
        end else if (wr_en) begin
            case (csr_addr)
                csr_addr_pkg::CSR_MTVEC:    mtvec    <= {csr_wdata[csr_addr_pkg::XLEN-1:2], 2'b00};
                csr_addr_pkg::CSR_MSCRATCH: mscratch <= csr_wdata;
                csr_addr_pkg::CSR_MEPC:     mepc     <= csr_wdata;
                csr_addr_pkg::CSR_MCAUSE:   mcause   <= csr_wdata;
                csr_addr_pkg::CSR_MTVAL:    mtval    <= csr_wdata;
                csr_addr_pkg::CSR_MIE:      mie      <= csr_wdata & mie_wmask;
                // mip, counters and unknown addresses drop the write
                default: ;
            endcase
        end
    end

endmodule

//--- csr_counters.sv
`timescale 1ns/1ps

module csr_counters #(
    parameter int CNT_WIDTH = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 retire,
    output logic [CNT_WIDTH-1:0] mcycle,
    output logic [CNT_WIDTH-1:0] minstret
);

    // free running from reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (retire) begin
            minstret <= minstret + 1'b1;
        end
    end

endmodule

//--- csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux #(
    parameter int CNT_WIDTH = 64
) (
    input  csr_addr_pkg::csr_addr_t       csr_raddr,
    input  logic [csr_addr_pkg::XLEN-1:0] mstatus,
    input  logic [csr_addr_pkg::XLEN-1:0] mie,
    input  logic [csr_addr_pkg::XLEN-1:0] mip,
    input  logic [csr_addr_pkg::XLEN-1:0] mtvec,
    input  logic [csr_addr_pkg::XLEN-1:0] mscratch,
    input  logic [csr_addr_pkg::XLEN-1:0] mepc,
    input  logic [csr_addr_pkg::XLEN-1:0] mcause,
    input  logic [csr_addr_pkg::XLEN-1:0] mtval,
    input  logic [CNT_WIDTH-1:0]          mcycle,
    input  logic [CNT_WIDTH-1:0]          minstret,
    output logic [csr_addr_pkg::XLEN-1:0] csr_rdata
);

    logic [csr_addr_pkg::XLEN-1:0] mcycle_ext;
    logic [csr_addr_pkg::XLEN-1:0] minstret_ext;

    // counters may be narrower than a CSR
    always_comb begin
        mcycle_ext   = '0;
        minstret_ext = '0;
        mcycle_ext[CNT_WIDTH-1:0]   = mcycle;
        minstret_ext[CNT_WIDTH-1:0] = minstret;
    end

    always_comb begin
        case (csr_raddr)
            csr_addr_pkg::CSR_MSTATUS:  csr_rdata = mstatus;
            csr_addr_pkg::CSR_MIE:      csr_rdata = mie;
            csr_addr_pkg::CSR_MIP:      csr_rdata = mip;
            csr_addr_pkg::CSR_MTVEC:    csr_rdata = mtvec;
            csr_addr_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            csr_addr_pkg::CSR_MEPC:     csr_rdata = mepc;
            csr_addr_pkg::CSR_MCAUSE:   csr_rdata = mcause;
            csr_addr_pkg::CSR_MTVAL:    csr_rdata = mtval;
            csr_addr_pkg::CSR_MCYCLE:   csr_rdata = mcycle_ext;
            csr_addr_pkg::CSR_MINSTRET: csr_rdata = minstret_ext;
            default:                    csr_rdata = '0;
        endcase
    end

endmodule

//--- csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter int CNT_WIDTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_types_pkg::commit_t        commit,
    input  csr_types_pkg::irq_lines_t     irq,
    input  csr_addr_pkg::csr_addr_t       csr_raddr,
    output logic [csr_addr_pkg::XLEN-1:0] csr_rdata,
    output csr_types_pkg::redirect_t      redirect,
    output csr_types_pkg::priv_e          priv
);

    csr_types_pkg::trap_update_t   trap;
    csr_addr_pkg::irq_cause_e      irq_cause;
    logic                          irq_pending;
    logic                          wr_en;
    logic                          retire;
    logic [csr_addr_pkg::XLEN-1:0] mstatus;
    logic [csr_addr_pkg::XLEN-1:0] mtvec;
    logic [csr_addr_pkg::XLEN-1:0] mscratch;
    logic [csr_addr_pkg::XLEN-1:0] mepc;
    logic [csr_addr_pkg::XLEN-1:0] mcause;
    logic [csr_addr_pkg::XLEN-1:0] mtval;
    logic [csr_addr_pkg::XLEN-1:0] mie;
    logic [csr_addr_pkg::XLEN-1:0] mip;
    logic [CNT_WIDTH-1:0]          mcycle;
    logic [CNT_WIDTH-1:0]          minstret;

    csr_trap_ctrl ctrl_i (
        .clk(clk), .rst(rst), .commit(commit), .irq_pending(irq_pending),
        .irq_cause(irq_cause), .mtvec(mtvec), .mepc(mepc), .trap(trap),
        .wr_en(wr_en), .retire(retire), .redirect(redirect), .priv(priv),
        .mstatus(mstatus)
    );

    csr_irq_arbiter arb_i (
        .mie(mie), .mip(mip), .priv(priv),
        .mstatus_mie(mstatus[csr_addr_pkg::MSTATUS_MIE_BIT]),
        .irq_pending(irq_pending), .irq_cause(irq_cause)
    );

    csr_machine_regs regs_i (
        .clk(clk), .rst(rst), .wr_en(wr_en), .csr_addr(commit.csr_addr),
        .csr_wdata(commit.csr_wdata), .trap(trap), .irq(irq), .mtvec(mtvec),
        .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval),
        .mie(mie), .mip(mip)
    );

    csr_counters #(.CNT_WIDTH(CNT_WIDTH)) cnt_i (
        .clk(clk), .rst(rst), .retire(retire), .mcycle(mcycle), .minstret(minstret)
    );

    csr_read_mux #(.CNT_WIDTH(CNT_WIDTH)) rmux_i (
        .csr_raddr(csr_raddr), .mstatus(mstatus), .mie(mie), .mip(mip),
        .mtvec(mtvec), .mscratch(mscratch), .mepc(mepc), .mcause(mcause),
        .mtval(mtval), .mcycle(mcycle), .minstret(minstret), .csr_rdata(csr_rdata)
    );

endmodule

//--- csr_unit_chk.sv
`timescale 1ns/1ps

module csr_trap_chk (
    input logic                        clk,
    input logic                        rst,
    input csr_types_pkg::commit_t      commit,
    input csr_types_pkg::trap_update_t trap,
    input csr_types_pkg::redirect_t    redirect,
    input csr_types_pkg::priv_e        priv
);

    redirect_needs_commit: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> commit.valid)
        else $error("redirect raised without a valid commit");

    // only M and U exist
    priv_legal: assert property (@(posedge clk) disable iff (rst)
        priv inside {csr_types_pkg::PRIV_M, csr_types_pkg::PRIV_U})
        else $error("priv holds an illegal encoding");

    trap_enters_m: assert property (@(posedge clk) disable iff (rst)
        trap.take |=> priv == csr_types_pkg::PRIV_M)
        else $error("taken trap did not switch to M mode");

endmodule

bind csr_trap_ctrl csr_trap_chk trap_chk_i (
    .clk(clk), .rst(rst), .commit(commit), .trap(trap), .redirect(redirect), .priv(priv)
);

//--- tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;

    localparam int XLEN = csr_addr_pkg::XLEN;
    // about 100 cycles of tests, wide margin
    localparam int MAX_CYCLES = 2000;

    logic                            clk;
    logic                            rst;
    csr_types_pkg::commit_t          commit;
    csr_types_pkg::irq_lines_t       irq;
    csr_addr_pkg::csr_addr_t         csr_raddr;
    logic [XLEN-1:0]                 csr_rdata;
    csr_types_pkg::redirect_t        redirect;
    csr_types_pkg::priv_e            priv;

    integer seed = 79;
    int     cycles = 0;
    int     chk_cnt = 0;
    int     err_cnt = 0;
    logic   checking = 1'b0;

    // reference state
    csr_types_pkg::priv_e      m_priv = csr_types_pkg::PRIV_M;
    csr_types_pkg::priv_e      m_mpp = csr_types_pkg::PRIV_U;
    logic                      m_mie_bit = 1'b0;
    logic                      m_mpie = 1'b0;
    logic [XLEN-1:0]           m_mtvec = '0;
    logic [XLEN-1:0]           m_mscratch = '0;
    logic [XLEN-1:0]           m_mepc = '0;
    logic [XLEN-1:0]           m_mcause = '0;
    logic [XLEN-1:0]           m_mtval = '0;
    logic [XLEN-1:0]           m_mie = '0;
    logic [XLEN-1:0]           m_cycle = '0;
    logic [XLEN-1:0]           m_instret = '0;
    csr_types_pkg::irq_lines_t m_irq = '0;

    csr_types_pkg::redirect_t  exp_redir;
    csr_types_pkg::priv_e      exp_priv;
    csr_addr_pkg::csr_addr_t   exp_raddr;
    logic [XLEN-1:0]           exp_rdata;

    // MSCRATCH, MTVEC, MIE, MEPC, MIP, unknown, MINSTRET, MCAUSE
    csr_addr_pkg::csr_addr_t addr_list [8] = '{12'h340, 12'h305, 12'h304, 12'h341,
                                              12'h344, 12'h7C0, 12'hB02, 12'h342};

    csr_unit #(.CNT_WIDTH(64)) dut_i (
        .clk(clk), .rst(rst), .commit(commit), .irq(irq), .csr_raddr(csr_raddr),
        .csr_rdata(csr_rdata), .redirect(redirect), .priv(priv)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [XLEN-1:0] lines_to_mip(input csr_types_pkg::irq_lines_t l);
        logic [XLEN-1:0] m;
        m = '0;
        m[3] = l.msip;
        m[7] = l.mtip;
        m[11] = l.meip;
        return m;
    endfunction

    function automatic csr_types_pkg::commit_t plain_op();
        csr_types_pkg::commit_t c;
        c = '0;
        c.valid = 1'b1;
        c.pc = rand64();
        return c;
    endfunction

    function automatic csr_types_pkg::commit_t csr_write_op(input csr_addr_pkg::csr_addr_t a,
                                                            input logic [XLEN-1:0] d);
        csr_types_pkg::commit_t c;
        c = plain_op();
        c.csr_we = 1'b1;
        c.csr_addr = a;
        c.csr_wdata = d;
        return c;
    endfunction

    function automatic void apply_csr_write(input csr_addr_pkg::csr_addr_t a,
                                            input logic [XLEN-1:0] d);
        case (a)
            12'h300: begin
                m_mie_bit = d[3];
                m_mpie = d[7];
                m_mpp = (d[12:11] == 2'b11) ? csr_types_pkg::PRIV_M : csr_types_pkg::PRIV_U;
            end
            12'h304: m_mie = d & 64'h888;
            12'h305: m_mtvec = {d[XLEN-1:2], 2'b00};
            12'h340: m_mscratch = d;
            12'h341: m_mepc = d;
            12'h342: m_mcause = d;
            12'h343: m_mtval = d;
            default: ;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] expected_csr(input csr_addr_pkg::csr_addr_t a);
        logic [XLEN-1:0] v;
        v = '0;
        case (a)
            12'h300: begin
                v[3] = m_mie_bit;
                v[7] = m_mpie;
                v[12:11] = m_mpp;
            end
            12'h304: v = m_mie;
            12'h344: v = lines_to_mip(m_irq);
            12'h305: v = m_mtvec;
            12'h340: v = m_mscratch;
            12'h341: v = m_mepc;
            12'h342: v = m_mcause;
            12'h343: v = m_mtval;
            12'hB00: v = m_cycle;
            12'hB02: v = m_instret;
            default: v = '0;
        endcase
        return v;
    endfunction

    // expected redirect of one commit; advances the reference state
    function automatic csr_types_pkg::redirect_t model_commit(input csr_types_pkg::commit_t c);
        csr_types_pkg::redirect_t r;
        logic [XLEN-1:0]          pend;
        logic                     irq_take;
        logic [3:0]               code;
        r = '0;
        pend = m_mie & lines_to_mip(m_irq);
        irq_take = (pend != '0) && (m_priv == csr_types_pkg::PRIV_U || m_mie_bit);
        code = pend[11] ? 4'd11 : (pend[3] ? 4'd3 : 4'd7);
        if (!c.valid) begin
            return r;
        end
        if (irq_take || c.except) begin
            r.valid = 1'b1;
            r.target = m_mtvec;
            m_mepc = c.pc;
            m_mcause = irq_take ? {1'b1, 59'd0, code} : c.ecause;
            m_mtval = irq_take ? '0 : c.tval;
            m_mpie = m_mie_bit;
            m_mie_bit = 1'b0;
            m_mpp = m_priv;
            m_priv = csr_types_pkg::PRIV_M;
        end else begin
            if (c.mret) begin
                r.valid = 1'b1;
                r.target = m_mepc;
                m_priv = m_mpp;
                m_mie_bit = m_mpie;
                m_mpie = 1'b1;
                m_mpp = csr_types_pkg::PRIV_U;
            end else begin
                m_instret = m_instret + 64'd1;
            end
            if (c.csr_we) begin
                apply_csr_write(c.csr_addr, c.csr_wdata);
            end
        end
        return r;
    endfunction

    // one cycle: drive commit, lines and read address, then predict
    task automatic step(input csr_types_pkg::commit_t c, input csr_types_pkg::irq_lines_t l,
                        input csr_addr_pkg::csr_addr_t a);
        @(posedge clk);
        commit <= c;
        irq <= l;
        csr_raddr <= a;
        m_irq = l;
        m_cycle = m_cycle + 64'd1;
        exp_priv = m_priv;
        exp_raddr = a;
        exp_rdata = expected_csr(a);
        exp_redir = model_commit(c);
        checking = 1'b1;
    endtask

    task automatic read_trap_state();
        step('0, '0, 12'h300);
        step('0, '0, 12'h341);
        step('0, '0, 12'h342);
        step('0, '0, 12'h343);
        step('0, '0, 12'h340);
    endtask

    always @(negedge clk) begin
        if (checking) begin
            chk_cnt = chk_cnt + 1;
            assert (redirect.valid == exp_redir.valid) else begin
                $display("** Error at %0t: redirect.valid expected %0b got %0b",
                         $time, exp_redir.valid, redirect.valid);
                err_cnt = err_cnt + 1;
            end
            assert (!exp_redir.valid || redirect.target == exp_redir.target) else begin
                $display("** Error at %0t: redirect.target expected %h got %h",
                         $time, exp_redir.target, redirect.target);
                err_cnt = err_cnt + 1;
            end
            assert (priv == exp_priv) else begin
                $display("** Error at %0t: priv expected %0d got %0d", $time, exp_priv, priv);
                err_cnt = err_cnt + 1;
            end
            assert (csr_rdata == exp_rdata) else begin
                $display("** Error at %0t: csr_rdata[%h] expected %h got %h",
                         $time, exp_raddr, exp_rdata, csr_rdata);
                err_cnt = err_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        csr_types_pkg::commit_t c;
        logic [2:0]             idx;
        rst = 1'b1;
        commit = '0;
        irq = '0;
        csr_raddr = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // write then read back, including dropped writes
        for (int i = 0; i < 8; i++) begin
            step(csr_write_op(addr_list[i], rand64() | 64'h3), '0, 12'h300);
            step('0, '0, addr_list[i]);
        end
        // exception from M with MIE set, carried write is dropped
        step(csr_write_op(12'h300, 64'h8), '0, 12'h300);
        c = csr_write_op(12'h340, rand64());
        c.except = 1'b1;
        c.ecause = 64'd2;
        c.tval = rand64();
        step(c, '0, 12'h340);
        read_trap_state();
        // mret into U with MPIE set
        step(csr_write_op(12'h300, 64'h80), '0, 12'h300);
        step(csr_write_op(12'h341, rand64()), '0, 12'h341);
        c = plain_op();
        c.mret = 1'b1;
        step(c, '0, 12'h341);
        read_trap_state();
        // timer interrupt from U, then M with MIE clear and set
        step(csr_write_op(12'h304, 64'hFFFF), '0, 12'h304);
        step(plain_op(), 3'b001, 12'h344);
        read_trap_state();
        step(plain_op(), 3'b001, 12'h344);
        step(csr_write_op(12'h300, 64'h8), '0, 12'h300);
        step(plain_op(), 3'b001, 12'h300);
        read_trap_state();
        // meip with mtip gives code 11
        step(csr_write_op(12'h300, 64'h8), '0, 12'h300);
        step(plain_op(), 3'b101, 12'h344);
        read_trap_state();
        // msip beats a simultaneous exception
        step(csr_write_op(12'h300, 64'h8), '0, 12'h300);
        c = plain_op();
        c.except = 1'b1;
        c.ecause = 64'd5;
        c.tval = rand64();
        step(c, 3'b010, 12'h344);
        read_trap_state();
        // U mode with MIE clear still takes it
        step(csr_write_op(12'h300, 64'h0), '0, 12'h300);
        c = plain_op();
        c.mret = 1'b1;
        step(c, '0, 12'h300);
        step(plain_op(), 3'b001, 12'h300);
        read_trap_state();
        // mcycle reads 8 cycles apart
        step('0, '0, 12'hB02);
        step('0, '0, 12'hB00);
        repeat (7) step('0, '0, 12'h000);
        step('0, '0, 12'hB00);
        for (int i = 0; i < 16; i++) begin
            idx = 3'($random(seed));
            c = (idx[0]) ? plain_op() : csr_write_op(addr_list[idx], rand64());
            step(c, '0, addr_list[3'($random(seed))]);
        end
        step('0, '0, 12'hB02);
        @(posedge clk);
        checking = 1'b0;
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
csr_addr_pkg.sv
csr_types_pkg.sv
csr_trap_ctrl.sv
csr_irq_arbiter.sv
csr_machine_regs.sv
csr_counters.sv
csr_read_mux.sv
csr_unit.sv
csr_unit_chk.sv
tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_csr_unit -f verilog.f -o sim_csr_unit \
    && ./obj_dir/sim_csr_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation FAILED" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "result: FAIL, run did not complete"; exit 1; }
echo "result: PASS"
